// File: common/arb_defs.svh
`ifndef ARB_DEFS_SVH
`define ARB_DEFS_SVH

// independent arbitration lanes
`define ARB_LANES       4

// requesters per lane
`define ARB_WIDTH       8

// clocks between enable strobes, small for simulation
`define ARB_STROBE_DIV  16

// width of a requester index
`define ARB_IDX_W       ($clog2(`ARB_WIDTH))

`endif

// File: common/arb_pkg.sv
`include "arb_defs.svh"

package arb_pkg;

    //--------------------------------------------------
    // per-lane vectors
    //--------------------------------------------------

    // one bit per requester
    typedef logic [`ARB_WIDTH-1:0] req_vec_t;

    // one-hot grant, all zero when nothing granted
    typedef logic [`ARB_WIDTH-1:0] gnt_vec_t;

    // requester index, also the last-grant pointer
    typedef logic [`ARB_IDX_W-1:0] req_idx_t;

    //--------------------------------------------------
    // flat buses across all lanes
    //--------------------------------------------------

    // request and one-hot grant buses, lane 0 in the low bits
    localparam int REQ_BUS_W = `ARB_LANES * `ARB_WIDTH;

endpackage

// File: common/grant_pkg.sv
`include "arb_defs.svh"

package grant_pkg;

    import arb_pkg::*;

    //--------------------------------------------------
    // collected result of one lane
    //--------------------------------------------------

    // idx only meaningful when valid is set
    typedef struct packed {
        req_idx_t idx;
        logic     valid;
    } lane_grant_t;

    // results of all lanes, lane 0 at index 0
    typedef lane_grant_t [`ARB_LANES-1:0] lane_grant_arr_t;

    // flat index bus on the top level
    localparam int IDX_BUS_W = `ARB_LANES * `ARB_IDX_W;

endpackage

// File: common/arb_lane_if.sv
`timescale 1ns/1ps

interface arb_lane_if import arb_pkg::*; ();

    // one-cycle enable strobe from the sampler
    logic     ena;

    // registered requests of this lane
    req_vec_t req;

    // one-hot grant, held between strobes
    gnt_vec_t gnt;

    // one-cycle pulse, gnt just changed
    logic     upd;

    // sampler side
    modport feed (
        output ena,
        output req
    );

    // arbiter side
    modport lane (
        input  ena,
        input  req,
        output gnt,
        output upd
    );

    // collector side
    modport drain (
        input  gnt,
        input  upd
    );

endinterface

// File: src/req_sampler.sv
`timescale 1ns/1ps

`include "arb_defs.svh"

module req_sampler import arb_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [REQ_BUS_W-1:0] req,
    arb_lane_if.feed             lanes [`ARB_LANES]
);

    // counter width, at least one bit
    localparam int CNT_W = (`ARB_STROBE_DIV > 1) ? $clog2(`ARB_STROBE_DIV) : 1;

    logic [REQ_BUS_W-1:0] req_q;
    logic [CNT_W-1:0]     div_cnt;
    logic                 wrap;
    logic                 ena_q;

    //--------------------------------------------------
    // request register
    //--------------------------------------------------

    // plain levels, one cycle of delay
    always_ff @(posedge clk)
    begin
        req_q <= req;
    end

    //--------------------------------------------------
    // strobe divider
    //--------------------------------------------------

    // last count of the period
    assign wrap = (div_cnt == CNT_W'(`ARB_STROBE_DIV - 1));

    // free running, modulo ARB_STROBE_DIV
    // first ena comes ARB_STROBE_DIV clocks after reset release
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            div_cnt <= '0;
            ena_q   <= 1'b0;
        end
        else
        begin
            if (wrap)
                div_cnt <= '0;
            else
                div_cnt <= div_cnt + 1'b1;
            // single cycle pulse on the wrap
            ena_q <= wrap;
        end
    end

    //--------------------------------------------------
    // fan out to the lanes
    //--------------------------------------------------

    for (genvar i = 0; i < `ARB_LANES; i++)
    begin : g_lane
        // lane i takes its slice of the flat bus
        assign lanes[i].req = req_vec_t'(req_q[i*`ARB_WIDTH +: `ARB_WIDTH]);
        // every lane sees the same strobe
        assign lanes[i].ena = ena_q;
    end

endmodule

// File: arbiter/rr_arbiter.sv
`timescale 1ns/1ps

`include "arb_defs.svh"

module rr_arbiter import arb_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    arb_lane_if.lane lane
);

    // last granted requester
    req_idx_t                  ptr;
    req_idx_t                  start;
    req_idx_t                  nxt_ptr;

    // rotated view, priority zero at bit 0
    logic [2*`ARB_WIDTH-1:0]   req_dbl;
    logic [2*`ARB_WIDTH-1:0]   gnt_dbl;
    req_vec_t                  rot_req;
    gnt_vec_t                  rot_gnt;
    gnt_vec_t                  gnt_next;

    gnt_vec_t                  gnt_q;
    logic                      upd_q;

    //--------------------------------------------------
    // rotate, pick, rotate back
    //--------------------------------------------------

    // search starts one above the pointer, wrapping at the top
    assign start = (ptr == req_idx_t'(`ARB_WIDTH - 1)) ? '0 : req_idx_t'(ptr + 1'b1);

    // rotate right so requester start lands on bit 0
    assign req_dbl = {lane.req, lane.req} >> start;
    assign rot_req = req_dbl[`ARB_WIDTH-1:0];

    // isolate lowest set bit
    assign rot_gnt = rot_req & (~rot_req + 1'b1);

    // rotate left by the same amount, upper half holds the result
    assign gnt_dbl  = {rot_gnt, rot_gnt} << start;
    assign gnt_next = gnt_dbl[2*`ARB_WIDTH-1:`ARB_WIDTH];

    // encode the new winner
    // pointer stays when no request is set
    always_comb
    begin
        nxt_ptr = ptr;
        for (int i = 0; i < `ARB_WIDTH; i++)
        begin
            if (gnt_next[i])
                nxt_ptr = req_idx_t'(i);
        end
    end

    //--------------------------------------------------
    // state
    //--------------------------------------------------

    // pointer resets to the top so requester 0 wins first
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ptr   <= req_idx_t'(`ARB_WIDTH - 1);
            gnt_q <= '0;
            upd_q <= 1'b0;
        end
        else
        begin
            // grant refreshed only on the strobe
            if (lane.ena)
            begin
                gnt_q <= gnt_next;
                ptr   <= nxt_ptr;
            end
            upd_q <= lane.ena;
        end
    end

    // held level and update pulse to the collector
    assign lane.gnt = gnt_q;
    assign lane.upd = upd_q;

endmodule

// File: src/grant_collector.sv
`timescale 1ns/1ps

`include "arb_defs.svh"

module grant_collector import arb_pkg::*, grant_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    arb_lane_if.drain             lanes [`ARB_LANES],
    output logic [REQ_BUS_W-1:0]  gnt,
    output logic [IDX_BUS_W-1:0]  gnt_idx,
    output logic [`ARB_LANES-1:0] gnt_valid,
    output logic                  grant_strobe
);

    logic [REQ_BUS_W-1:0] gnt_flat;
    lane_grant_arr_t      enc;
    lane_grant_arr_t      res_q;
    logic [REQ_BUS_W-1:0] gnt_q;
    logic                 strobe_q;

    // gather the one-hot grants, lane 0 in the low bits
    for (genvar i = 0; i < `ARB_LANES; i++)
    begin : g_in
        assign gnt_flat[i*`ARB_WIDTH +: `ARB_WIDTH] = lanes[i].gnt;
    end

    //--------------------------------------------------
    // one-hot to index
    //--------------------------------------------------

    always_comb
    begin
        for (int l = 0; l < `ARB_LANES; l++)
        begin
            enc[l].idx   = '0;
            enc[l].valid = |gnt_flat[l*`ARB_WIDTH +: `ARB_WIDTH];
            for (int b = 0; b < `ARB_WIDTH; b++)
            begin
                if (gnt_flat[l*`ARB_WIDTH + b])
                    enc[l].idx = req_idx_t'(b);
            end
        end
    end

    //--------------------------------------------------
    // output registers
    //--------------------------------------------------

    // all lanes update together, lane 0 stands for them
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            res_q    <= '0;
            gnt_q    <= '0;
            strobe_q <= 1'b0;
        end
        else
        begin
            if (lanes[0].upd)
            begin
                res_q <= enc;
                gnt_q <= gnt_flat;
            end
            strobe_q <= lanes[0].upd;
        end
    end

    // flatten the records onto the ports
    for (genvar i = 0; i < `ARB_LANES; i++)
    begin : g_out
        assign gnt_idx[i*`ARB_IDX_W +: `ARB_IDX_W] = res_q[i].idx;
        assign gnt_valid[i]                        = res_q[i].valid;
    end

    assign gnt          = gnt_q;
    assign grant_strobe = strobe_q;

endmodule

// File: src/arb_top.sv
`timescale 1ns/1ps

`include "arb_defs.svh"

module arb_top import arb_pkg::*, grant_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,

    // flat requests, lane 0 in the low bits
    input  logic [REQ_BUS_W-1:0]  req,

    // one-hot grants of all lanes
    output logic [REQ_BUS_W-1:0]  gnt,

    // encoded grants and their valid bits
    output logic [IDX_BUS_W-1:0]  gnt_idx,
    output logic [`ARB_LANES-1:0] gnt_valid,

    // one cycle per strobe, outputs just changed
    output logic                  grant_strobe
);

    //--------------------------------------------------
    // one bundle per lane
    //--------------------------------------------------

    arb_lane_if lane_if [`ARB_LANES] ();

    //--------------------------------------------------
    // feeder
    //--------------------------------------------------

    // request register and enable strobe
    req_sampler u_req_sampler
    (
        .clk   ( clk     ),
        .rst_n ( rst_n   ),
        .req   ( req     ),
        .lanes ( lane_if )
    );

    //--------------------------------------------------
    // lanes
    //--------------------------------------------------

    // identical rotating-priority arbiters
    for (genvar i = 0; i < `ARB_LANES; i++)
    begin : g_lane
        rr_arbiter u_lane
        (
            .clk   ( clk        ),
            .rst_n ( rst_n      ),
            .lane  ( lane_if[i] )
        );
    end

    //--------------------------------------------------
    // drain
    //--------------------------------------------------

    // encode and register onto the top-level ports
    grant_collector u_grant_collector
    (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .lanes        ( lane_if      ),
        .gnt          ( gnt          ),
        .gnt_idx      ( gnt_idx      ),
        .gnt_valid    ( gnt_valid    ),
        .grant_strobe ( grant_strobe )
    );

endmodule

// File: tb/arb_top_sva.sv
`timescale 1ns/1ps

`include "arb_defs.svh"

module arb_top_sva import arb_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [REQ_BUS_W-1:0] req,
    input  logic [REQ_BUS_W-1:0] gnt,
    input  logic                 upd,
    input  logic                 grant_strobe
);

    //--------------------------------------------------
    // per-lane grant shape
    //--------------------------------------------------

    // at most one winner per lane
    for (genvar i = 0; i < `ARB_LANES; i++)
    begin : g_lane
        a_onehot: assert property (@(posedge clk) disable iff (!rst_n)
            $onehot0(gnt[i*`ARB_WIDTH +: `ARB_WIDTH]))
            else $error("lane %0d grant has more than one bit set", i);
    end

    //--------------------------------------------------
    // timing against requests and update pulse
    //--------------------------------------------------

    // input req three samples back is what the sampler handed on
    a_requested: assert property (@(posedge clk) disable iff (!rst_n)
        grant_strobe |-> ((gnt & ~$past(req, 3)) == '0))
        else $error("grant given to a requester that was not requesting");

    // outputs move only in the cycle after upd
    a_stable: assert property (@(posedge clk) disable iff (!rst_n)
        !upd |=> $stable(gnt))
        else $error("grant output changed without an update pulse");

    // collector strobes on lane 0, upd here comes from the last lane
    a_follow: assert property (@(posedge clk) disable iff (!rst_n)
        grant_strobe == $past(upd))
        else $error("grant strobe does not follow the update pulse");

endmodule

bind arb_top arb_top_sva u_arb_top_sva
(
    .clk          ( clk                         ),
    .rst_n        ( rst_n                       ),
    .req          ( req                         ),
    .gnt          ( gnt                         ),
    .upd          ( lane_if[`ARB_LANES-1].upd   ),
    .grant_strobe ( grant_strobe                )
);

// File: tb/arb_checker.sv
`timescale 1ns/1ps

`include "arb_defs.svh"

module arb_checker import arb_pkg::*, grant_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    // DUT outputs
    input  logic [REQ_BUS_W-1:0]  gnt,
    input  logic [IDX_BUS_W-1:0]  gnt_idx,
    input  logic [`ARB_LANES-1:0] gnt_valid,
    input  logic                  grant_strobe,
    // model results for the coming strobe
    input  logic [REQ_BUS_W-1:0]  exp_gnt,
    input  logic [IDX_BUS_W-1:0]  exp_idx,
    input  logic [`ARB_LANES-1:0] exp_valid,
    output int                    err_count,
    output int                    check_count
);

    localparam int W  = `ARB_WIDTH;
    localparam int IW = `ARB_IDX_W;

    int errors = 0;
    int checks = 0;

    //--------------------------------------------------
    // compare on every grant strobe
    //--------------------------------------------------

    // mid-cycle, outputs settled since the rising edge
    always @(negedge clk)
    begin
        if (rst_n && grant_strobe)
        begin
            checks++;
            for (int l = 0; l < `ARB_LANES; l++)
            begin
                if (gnt[l*W +: W] !== exp_gnt[l*W +: W])
                begin
                    $display("error gnt lane %0d expected %h got %h",
                             l, exp_gnt[l*W +: W], gnt[l*W +: W]);
                    errors++;
                end
                if (gnt_valid[l] !== exp_valid[l])
                begin
                    $display("error gnt_valid lane %0d expected %h got %h",
                             l, exp_valid[l], gnt_valid[l]);
                    errors++;
                end
                // index only defined with a grant
                if (exp_valid[l] && (gnt_idx[l*IW +: IW] !== exp_idx[l*IW +: IW]))
                begin
                    $display("error gnt_idx lane %0d expected %h got %h",
                             l, exp_idx[l*IW +: IW], gnt_idx[l*IW +: IW]);
                    errors++;
                end
            end
        end
    end

    assign err_count   = errors;
    assign check_count = checks;

endmodule

// File: tb/tb_arb_top.sv
`timescale 1ns/1ps

`include "arb_defs.svh"

module tb_arb_top import arb_pkg::*, grant_pkg::*;
();

    localparam int W  = `ARB_WIDTH;
    localparam int IW = `ARB_IDX_W;

    logic                  clk;
    logic                  rst_n;
    logic [REQ_BUS_W-1:0]  req;
    logic [REQ_BUS_W-1:0]  gnt;
    logic [IDX_BUS_W-1:0]  gnt_idx;
    logic [`ARB_LANES-1:0] gnt_valid;
    logic                  grant_strobe;

    // model results for the next strobe
    logic [REQ_BUS_W-1:0]  exp_gnt;
    logic [IDX_BUS_W-1:0]  exp_idx;
    logic [`ARB_LANES-1:0] exp_valid;

    // one model pointer per lane
    req_idx_t model_ptr [`ARB_LANES];

    int seed;
    int err_count;
    int check_count;
    int timeouts;
    int marks;
    int tests_passed;
    int tests_failed;
    logic [REQ_BUS_W-1:0] pat;

    // 20 ns period
    initial clk = 1'b0;
    always #10 clk = ~clk;

    arb_top u_arb_top
    (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .req          ( req          ),
        .gnt          ( gnt          ),
        .gnt_idx      ( gnt_idx      ),
        .gnt_valid    ( gnt_valid    ),
        .grant_strobe ( grant_strobe )
    );

    arb_checker u_arb_checker
    (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .gnt          ( gnt          ),
        .gnt_idx      ( gnt_idx      ),
        .gnt_valid    ( gnt_valid    ),
        .grant_strobe ( grant_strobe ),
        .exp_gnt      ( exp_gnt      ),
        .exp_idx      ( exp_idx      ),
        .exp_valid    ( exp_valid    ),
        .err_count    ( err_count    ),
        .check_count  ( check_count  )
    );

    //--------------------------------------------------
    // reference model
    //--------------------------------------------------

    // walk upward from ptr+1, wrapping, first request wins
    function automatic gnt_vec_t next_grant(input req_vec_t r, input req_idx_t p,
                                            output req_idx_t p_new);
        gnt_vec_t g;
        int       idx;
        g     = '0;
        p_new = p;
        for (int k = 1; k <= W; k++)
        begin
            idx = (int'(p) + k) % W;
            if (r[idx] && (g == '0))
            begin
                g[idx] = 1'b1;
                p_new  = req_idx_t'(idx);
            end
        end
        return g;
    endfunction

    // one lane's bits placed on the flat bus
    function automatic logic [REQ_BUS_W-1:0] on_lane(input int lane, input req_vec_t bits);
        logic [REQ_BUS_W-1:0] v;
        v = '0;
        v[lane*W +: W] = bits;
        return v;
    endfunction

    //--------------------------------------------------
    // one strobe: drive, predict, wait
    //--------------------------------------------------

    task automatic run_strobe(input logic [REQ_BUS_W-1:0] pattern);
        req_idx_t p_new;
        gnt_vec_t g;
        int       cycles;
        bit       seen;
        @(posedge clk);
        req <= pattern;
        for (int l = 0; l < `ARB_LANES; l++)
        begin
            g              = next_grant(pattern[l*W +: W], model_ptr[l], p_new);
            model_ptr[l]   = p_new;
            exp_gnt[l*W +: W]   = g;
            exp_idx[l*IW +: IW] = (g != '0) ? p_new : '0;
            exp_valid[l]        = |g;
        end
        // sampled mid-cycle, bounded
        cycles = 0;
        seen   = 1'b0;
        while (!seen && (cycles < 4 * `ARB_STROBE_DIV))
        begin
            @(negedge clk);
            cycles++;
            if (grant_strobe)
                seen = 1'b1;
        end
        if (!seen)
        begin
            $display("grant strobe never arrived");
            timeouts++;
        end
    endtask

    task automatic start_test();
        marks = err_count + timeouts;
    endtask

    // one result line per test
    task automatic report_test(input int num, input string name);
        int bad;
        // checker compares on the same negedge
        @(posedge clk);
        bad = err_count + timeouts - marks;
        if (bad == 0)
        begin
            $display("test %0d %s: passed", num, name);
            tests_passed++;
        end
        else
        begin
            $display("test %0d %s: %0d problems", num, name, bad);
            tests_failed++;
        end
    endtask

    //--------------------------------------------------
    // sequence
    //--------------------------------------------------

    initial
    begin
        seed         = 32'hc379_626d;
        rst_n        = 1'b0;
        req          = '0;
        exp_gnt      = '0;
        exp_idx      = '0;
        exp_valid    = '0;
        timeouts     = 0;
        marks        = 0;
        tests_passed = 0;
        tests_failed = 0;
        for (int l = 0; l < `ARB_LANES; l++)
            model_ptr[l] = req_idx_t'(W - 1);

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        // idle after reset
        start_test();
        run_strobe('0);
        report_test(1, "idle after reset");

        // full rotation on lane 0
        start_test();
        repeat (W + 1) run_strobe(on_lane(0, 8'hff));
        report_test(2, "full rotation");

        // 2 and 5, then 2 alone
        start_test();
        repeat (3) run_strobe(on_lane(1, 8'h24));
        repeat (3) run_strobe(on_lane(1, 8'h04));
        report_test(3, "sparse requests");

        // each lane its own pattern
        start_test();
        pat = on_lane(0, 8'h81) | on_lane(1, 8'h1a) | on_lane(2, 8'h66) | on_lane(3, 8'hf0);
        repeat (8) run_strobe(pat);
        report_test(4, "independent lanes");

        // drop and resume on lane 2
        start_test();
        repeat (2) run_strobe(on_lane(2, 8'h0f));
        repeat (2) run_strobe('0);
        repeat (2) run_strobe(on_lane(2, 8'hff));
        report_test(5, "drop and resume");

        // random, changed only between strobes
        start_test();
        repeat (200)
        begin
            for (int l = 0; l < `ARB_LANES; l++)
                pat[l*W +: W] = req_vec_t'($random(seed));
            run_strobe(pat);
        end
        report_test(6, "random requests");

        $display("tests passed %0d failed %0d, strobes checked %0d, mismatches %0d",
                 tests_passed, tests_failed, check_count, err_count);
        if ((tests_failed == 0) && (err_count == 0) && (timeouts == 0) && (check_count > 0))
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

// File: sim.f
+incdir+common
common/arb_pkg.sv
common/grant_pkg.sv
common/arb_lane_if.sv
src/req_sampler.sv
arbiter/rr_arbiter.sv
src/grant_collector.sv
src/arb_top.sv
tb/arb_top_sva.sv
tb/arb_checker.sv
tb/tb_arb_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_arb_top
FILELIST  := sim.f

OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := Everything OK

# every source named in the file list, plus the shared header
SRCS := $(shell grep -v '^+' $(FILELIST)) common/arb_defs.svh

.PHONY: all run check clean

all: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx '$(PASS_MSG)' $(LOG)

check: run

clean:
	rm -rf $(OBJ_DIR) $(LOG)
